// ==== verilog/mem_pkg.sv ====
package mem_pkg;

    // ******************************
    // sizes
    // ******************************

    localparam int MEM_WORDS = 64;                   // 32-bit words held by the data memory
    localparam int MEM_AW = $clog2(MEM_WORDS);       // word index width taken from the address

    localparam int REQ_DEPTH = 4;                    // queue entries, also the requester's credits
    localparam int REQ_PW = $clog2(REQ_DEPTH);       // queue pointer width

    localparam int RSP_CREDITS = 2;                  // response credits the port owns after reset
    localparam int RSP_CW = $clog2(RSP_CREDITS + 1); // counter must hold the full credit value

    // ******************************
    // encodings
    // ******************************

    // access type of a load or store, the u variants zero-extend on read
    typedef enum logic [2:0] {
        MEM_DT_BYTE  = 3'd0,
        MEM_DT_HALF  = 3'd1,
        MEM_DT_WORD  = 3'd2,
        MEM_DT_UBYTE = 3'd3,
        MEM_DT_UHALF = 3'd4
    } mem_dt_e;

    typedef enum logic {
        ERR_NONE  = 1'b0,
        ERR_ALIGN = 1'b1  // half at an odd address or word off a 4-byte boundary
    } errno_e;

    // memory port sequencer state
    typedef enum logic {
        PORT_IDLE  = 1'b0,
        PORT_ISSUE = 1'b1
    } port_state_e;

    // ******************************
    // payloads
    // ******************************

    // one load or store as sent by the requester, 68 bits
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wd;   // store data, ignored on loads
        logic        we;   // set for a store
        mem_dt_e     dt;
    } mem_req_t;

    // one response per request, 33 bits
    typedef struct packed {
        logic [31:0] rd;   // load data, extended per access type
        errno_e      err;
    } mem_rsp_t;

endpackage

// ==== verilog/mem_be.sv ====
`timescale 1ns/1ps

module mem_be (
    input  logic                        clk,
    input  logic [mem_pkg::MEM_AW-1:0]  word_addr,
    input  logic [31:0]                 wd,
    input  logic [3:0]                  be,
    input  logic                        we,
    input  logic                        se,
    output logic [31:0]                 rd
);
    import mem_pkg::*;

    logic [31:0] mem_q [MEM_WORDS];  // storage array, contents are never cleared
    logic [31:0] wdata;              // store data replicated into every lane it may land in
    logic [31:0] word;               // the addressed word as stored

    // ******************************
    // write side
    // ******************************

    // the store value always sits in the low bytes of wd, so it is
    // copied across the word and the enables pick which copy lands
    always_comb begin
        case (be)
            4'b0001,
            4'b0010,
            4'b0100,
            4'b1000: wdata = {4{wd[7:0]}};   // single byte in any lane
            4'b0011,
            4'b1100: wdata = {2{wd[15:0]}};  // lower or upper half
            default: wdata = wd;             // full word
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we && be[i]) begin
                mem_q[word_addr][8*i +: 8] <= wdata[8*i +: 8];  // only enabled lanes change
            end
        end
    end

    // ******************************
    // read side
    // ******************************

    assign word = mem_q[word_addr];  // read is asynchronous

    // selected lanes come back right-aligned
    // the fill bit is the lane MSB when se is set, zero otherwise
    always_comb begin
        case (be)
            4'b0001: rd = {{24{se & word[7]}},  word[7:0]};
            4'b0010: rd = {{24{se & word[15]}}, word[15:8]};
            4'b0100: rd = {{24{se & word[23]}}, word[23:16]};
            4'b1000: rd = {{24{se & word[31]}}, word[31:24]};

            4'b0011: rd = {{16{se & word[15]}}, word[15:0]};
            4'b1100: rd = {{16{se & word[31]}}, word[31:16]};

            default: rd = word;  // full word is returned untouched
        endcase
    end

endmodule

// ==== verilog/mem.sv ====
`timescale 1ns/1ps

module mem (
    input  logic               clk,
    input  logic [31:0]        addr,
    input  logic [31:0]        wd,
    input  logic               we,
    input  mem_pkg::mem_dt_e   dt,
    output logic [31:0]        rd,
    output mem_pkg::errno_e    err
);
    import mem_pkg::*;

    logic [3:0] b_be;      // one-hot lane for byte accesses
    logic [3:0] h_be;      // lane pair for half accesses
    logic [3:0] be;
    logic       se;
    logic       mem_we;    // write enable after the alignment check

    // ******************************
    // byte enable decode
    // ******************************

    assign b_be = 4'b0001 << addr[1:0];                // lane picked by the low address bits
    assign h_be = addr[1] ? 4'b1100 : 4'b0011;         // bit 1 picks upper or lower half

    // the access type chooses the lane pattern and whether loads sign-extend
    always_comb begin
        case (dt)
            MEM_DT_BYTE:  begin be = b_be;    se = 1'b1; end
            MEM_DT_HALF:  begin be = h_be;    se = 1'b1; end
            MEM_DT_UBYTE: begin be = b_be;    se = 1'b0; end
            MEM_DT_UHALF: begin be = h_be;    se = 1'b0; end
            default:      begin be = 4'b1111; se = 1'b0; end  // word, and unused codes
        endcase
    end

    // ******************************
    // alignment check
    // ******************************

    always_comb begin
        case (dt)
            MEM_DT_HALF,
            MEM_DT_UHALF: err = addr[0] ? ERR_ALIGN : ERR_NONE;      // halves need an even address
            MEM_DT_WORD:  err = (|addr[1:0]) ? ERR_ALIGN : ERR_NONE;
            default:      err = ERR_NONE;                            // bytes are always aligned
        endcase
    end

    // a faulting store must leave memory as it was
    assign mem_we = we && (err == ERR_NONE);

    mem_be u_be (
        .clk       (clk),
        .word_addr (addr[MEM_AW+1:2]),  // word index, upper address bits wrap
        .wd        (wd),
        .be        (be),
        .we        (mem_we),
        .se        (se),
        .rd        (rd)
    );

endmodule

// ==== verilog/req_queue.sv ====
`timescale 1ns/1ps

module req_queue (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  mem_pkg::mem_req_t   req,
    output logic                req_credit,
    output logic                head_valid,
    output mem_pkg::mem_req_t   head,
    input  logic                pop
);
    import mem_pkg::*;

    mem_req_t          fifo_q [REQ_DEPTH];  // circular buffer, payload only
    logic [REQ_PW-1:0] wr_ptr;
    logic [REQ_PW-1:0] rd_ptr;
    logic [REQ_PW:0]   count;               // occupancy, one bit wider to reach REQ_DEPTH
    logic              do_pop;

    // there is no ready signal, the requester's credits keep count at or below REQ_DEPTH
    assign head_valid = (count != '0);
    assign head       = fifo_q[rd_ptr];     // oldest entry, visible the cycle after its write
    assign do_pop     = pop && head_valid;  // a pop on an empty queue is ignored

    // ******************************
    // storage
    // ******************************

    always_ff @(posedge clk) begin
        if (req_valid) begin
            fifo_q[wr_ptr] <= req;
        end
    end

    // ******************************
    // pointers, count and credits
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two so the pointer wraps itself
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            // a push and a pop in one cycle leave the occupancy unchanged
            case ({req_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // every released entry hands one credit back, one cycle after the pop
            req_credit <= do_pop;
        end
    end

endmodule

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ps

module mem_port (
    input  logic                clk,
    input  logic                reset,
    input  logic                head_valid,
    input  mem_pkg::mem_req_t   head,
    output logic                pop,
    input  logic [31:0]         rd,
    input  mem_pkg::errno_e     err,
    output logic [31:0]         addr,
    output logic [31:0]         wd,
    output logic                we,
    output mem_pkg::mem_dt_e    dt,
    output logic                rsp_valid,
    output mem_pkg::mem_rsp_t   rsp,
    input  logic                rsp_credit
);
    import mem_pkg::*;

    port_state_e       state;
    port_state_e       state_nxt;
    logic [RSP_CW-1:0] credits;  // responses the consumer can still accept

    // ******************************
    // issue decision
    // ******************************

    // a request leaves the queue only when its response has somewhere to go,
    // this is decided in the same cycle whatever the state
    assign pop = head_valid && (credits != '0);

    // the head entry goes straight to the memory, read data returns this cycle
    assign addr = head.addr;
    assign wd   = head.wd;
    assign dt   = head.dt;
    assign we   = head.we && pop;  // a store commits only on the edge that pops it

    always_comb begin
        state_nxt = state;
        case (state)
            PORT_IDLE:  if (pop) state_nxt = PORT_ISSUE;          // work and a credit appeared
            PORT_ISSUE: if (!head_valid) state_nxt = PORT_IDLE;   // queue has drained
            default:    state_nxt = PORT_IDLE;
        endcase
    end

    // ******************************
    // state, credits and response
    // ******************************

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= PORT_IDLE;
            credits   <= RSP_CW'(RSP_CREDITS);
            rsp_valid <= 1'b0;
        end else begin
            state <= state_nxt;

            // a pop spends a credit and a returned one refills it, both may land together
            case ({pop, rsp_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            rsp_valid <= pop;  // one response cycle per popped request
        end
    end

    // response payload is captured at the pop edge, same edge as the store
    always_ff @(posedge clk) begin
        if (pop) begin
            rsp.rd  <= rd;
            rsp.err <= err;
        end
    end

endmodule

// ==== verilog/mem_subsys.sv ====
`timescale 1ns/1ps

module mem_subsys (
    input  logic                clk,
    input  logic                reset,
    input  logic                req_valid,
    input  mem_pkg::mem_req_t   req,
    output logic                req_credit,
    output logic                rsp_valid,
    output mem_pkg::mem_rsp_t   rsp,
    input  logic                rsp_credit
);
    import mem_pkg::*;

    // queue to port
    logic      head_valid;
    mem_req_t  head;
    logic      pop;

    // port to memory, all combinational within one cycle
    logic [31:0] addr;
    logic [31:0] wd;
    logic        we;
    mem_dt_e     dt;
    logic [31:0] rd;
    errno_e      err;

    // ******************************
    // request queue
    // ******************************

    req_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop)
    );

    // ******************************
    // memory port and storage
    // ******************************

    mem_port u_port (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .rd         (rd),
        .err        (err),
        .addr       (addr),
        .wd         (wd),
        .we         (we),
        .dt         (dt),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    mem u_mem (
        .clk  (clk),
        .addr (addr),
        .wd   (wd),
        .we   (we),
        .dt   (dt),
        .rd   (rd),
        .err  (err)
    );

endmodule

// ==== test/mem_subsys_checker.sv ====
`timescale 1ns/1ps

module mem_subsys_checker (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req_credit,
    input  logic                          rsp_valid,
    input  logic [mem_pkg::REQ_PW:0]      count,    // queue occupancy
    input  logic [mem_pkg::RSP_CW-1:0]    credits   // response credits held by the port
);
    import mem_pkg::*;

    // ******************************
    // credit rules
    // ******************************

    // the requester's credits bound the queue, it can never hold more than its depth
    a_queue_bound: assert property (@(posedge clk) disable iff (reset)
        count <= REQ_DEPTH)
        else $error("request queue occupancy above its depth");

    // a response is only sent out of a cycle in which the port still held a credit
    a_rsp_credit: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |-> $past(credits) != '0)
        else $error("response issued with no response credit");

    // one response cycle per queue entry released, so a single pop
    // cannot stretch rsp_valid over a second cycle
    a_rsp_single: assert property (@(posedge clk) disable iff (reset)
        rsp_valid == req_credit)
        else $error("response cycles out of step with released queue entries");

    // ******************************
    // reset rule
    // ******************************

    a_reset_quiet: assert property (@(posedge clk)
        reset |=> (!req_credit && !rsp_valid))
        else $error("credit or response active right after reset");

endmodule

// ==== test/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int CLK_HALF = 4;                       // 8 ns clock
    localparam int N_RANDOM = 40;
    localparam int TOTAL_REQS = 72 + 16 + 8 + REQ_DEPTH + RSP_CREDITS + N_RANDOM;
    localparam int CYCLE_BUDGET = 16;                  // generous per-request allowance

    logic clk;
    logic reset;
    logic req_valid;
    mem_req_t req;
    logic req_credit;
    logic rsp_valid;
    mem_rsp_t rsp;
    logic rsp_credit;

    integer seed = 32'h461c;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int req_credits;                // requester side credit counter
    int owed = 0;                   // response credits not yet handed back
    int rsp_count = 0;              // responses seen over the whole run
    bit hold_credits = 0;           // withhold every response credit
    bit random_credits = 0;         // hand credits back on random cycles
    logic [7:0] ref_mem [MEM_WORDS*4];  // byte-wide reference memory, little endian
    mem_rsp_t exp_q [$];            // expected responses in request order
    bit rd_chk_q [$];               // rd is only defined for aligned loads

    mem_subsys dut (.*);

    bind mem_subsys mem_subsys_checker u_checker (
        .clk(clk), .reset(reset), .req_credit(req_credit), .rsp_valid(rsp_valid),
        .count(u_queue.count), .credits(u_port.credits)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // watchdog sized from the request count of all tests
    initial begin
        #(2 * CLK_HALF * (TOTAL_REQS * CYCLE_BUDGET + 8));
        $display("timeout, the tests did not finish within the cycle budget");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // ******************************
    // reference model
    // ******************************

    task automatic predict(input mem_req_t r);
        mem_rsp_t exp;
        int base;
        int nbytes;
        int i;
        logic sext;
        logic misaligned;
        base = int'(r.addr[MEM_AW+1:0]);  // upper address bits wrap onto the array
        case (r.dt)
            MEM_DT_BYTE, MEM_DT_UBYTE: nbytes = 1;
            MEM_DT_HALF, MEM_DT_UHALF: nbytes = 2;
            default:                   nbytes = 4;
        endcase
        sext = (r.dt == MEM_DT_BYTE) || (r.dt == MEM_DT_HALF);
        misaligned = (base % nbytes) != 0;
        exp.err = misaligned ? ERR_ALIGN : ERR_NONE;
        exp.rd = '0;
        if (!misaligned) begin
            for (i = nbytes - 1; i >= 0; i--) exp.rd = (exp.rd << 8) | ref_mem[base + i];
            if (sext && nbytes < 4 && exp.rd[8*nbytes-1]) begin
                exp.rd = exp.rd | (32'hffff_ffff << (8 * nbytes));  // fill with the lane MSB
            end
            if (r.we) begin
                for (i = 0; i < nbytes; i++) ref_mem[base + i] = r.wd[8*i +: 8];
            end
        end
        exp_q.push_back(exp);
        rd_chk_q.push_back(!r.we && !misaligned);
    endtask

    function automatic logic [31:0] fill_word(input int a);
        return 32'h9e37_79b9 * 32'(a + 1);  // differs for every byte address
    endfunction

    // ******************************
    // requester and consumer
    // ******************************

    task automatic take_response();
        mem_rsp_t exp;
        bit chk;
        rsp_count++;
        owed++;
        if (exp_q.size() == 0) begin
            $display("response arrived with no request outstanding");
            errors++;
        end else begin
            exp = exp_q.pop_front();
            chk = rd_chk_q.pop_front();
            check("rsp.err", 32'(rsp.err), 32'(exp.err));
            if (chk) check("rsp.rd", rsp.rd, exp.rd);
        end
    endtask

    // one cycle, outputs sampled at the falling edge where they are settled
    task automatic step();
        @(negedge clk);
        if (req_credit) req_credits++;
        if (rsp_valid) take_response();
        req_valid = 1'b0;
        rsp_credit = 1'b0;
        if (owed > 0 && !hold_credits && (!random_credits || ($random(seed) & 3) == 0)) begin
            rsp_credit = 1'b1;  // one credit per pulse
            owed--;
        end
    endtask

    task automatic send(input logic [31:0] addr, input logic [31:0] wd, input logic we,
                        input mem_dt_e dt);
        step();
        while (req_credits == 0) step();  // stall until the queue returns a credit
        req.addr = addr;
        req.wd = wd;
        req.we = we;
        req.dt = dt;
        req_valid = 1'b1;
        req_credits--;
        predict(req);
    endtask

    task automatic drain(input string name, input int err_before);
        while (exp_q.size() != 0 || owed != 0) step();
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    // ******************************
    // tests
    // ******************************

    task automatic test_words();
        int e;
        int k;
        e = errors;
        for (k = 0; k < MEM_WORDS; k++) send(4 * k, fill_word(4 * k), 1'b1, MEM_DT_WORD);
        for (k = 0; k < 8; k++) send((k * 32'h24) & 32'hfc, '0, 1'b0, MEM_DT_WORD);
        drain("word store and load", e);
    endtask

    task automatic test_lanes();
        int e;
        int k;
        e = errors;
        send(32'h40, 32'h1122_3344, 1'b1, MEM_DT_WORD);
        send(32'h41, 32'hffff_ff85, 1'b1, MEM_DT_BYTE);   // only the low byte is stored
        send(32'h42, 32'h0000_1abc, 1'b1, MEM_DT_HALF);   // upper half gets a clear MSB
        for (k = 0; k < 4; k++) begin
            send(32'h40 + k, '0, 1'b0, MEM_DT_BYTE);
            send(32'h40 + k, '0, 1'b0, MEM_DT_UBYTE);
        end
        for (k = 0; k < 4; k += 2) begin
            send(32'h40 + k, '0, 1'b0, MEM_DT_HALF);
            send(32'h40 + k, '0, 1'b0, MEM_DT_UHALF);
        end
        send(32'h40, '0, 1'b0, MEM_DT_WORD);
        drain("byte and half lanes", e);
    endtask

    task automatic test_align();
        int e;
        e = errors;
        send(32'h80, 32'hcafe_f00d, 1'b1, MEM_DT_WORD);
        send(32'h81, 32'h1111_1111, 1'b1, MEM_DT_HALF);   // each of these must fault
        send(32'h82, 32'h2222_2222, 1'b1, MEM_DT_WORD);
        send(32'h83, 32'h3333_3333, 1'b1, MEM_DT_WORD);
        send(32'h83, '0, 1'b0, MEM_DT_HALF);
        send(32'h81, '0, 1'b0, MEM_DT_UHALF);
        send(32'h81, '0, 1'b0, MEM_DT_WORD);
        send(32'h80, '0, 1'b0, MEM_DT_WORD);              // word must be untouched
        drain("alignment errors", e);
    endtask

    task automatic test_backpressure();
        int e;
        int base;
        int k;
        e = errors;
        base = rsp_count;
        hold_credits = 1'b1;
        for (k = 0; k < REQ_DEPTH + RSP_CREDITS; k++) send(4 * k, '0, 1'b0, MEM_DT_WORD);
        repeat (16) step();
        check("responses under back-pressure", 32'(rsp_count - base), 32'(RSP_CREDITS));
        check("requester credits", 32'(req_credits), 32'd0);
        hold_credits = 1'b0;
        drain("back-pressure", e);
    endtask

    task automatic test_random();
        int e;
        int k;
        logic [2:0] dt_sel;
        e = errors;
        random_credits = 1'b1;
        for (k = 0; k < N_RANDOM; k++) begin
            dt_sel = $unsigned($random(seed)) % 5;
            send($random(seed), $random(seed), $random(seed) & 1, mem_dt_e'(dt_sel));
        end
        drain("random accesses", e);
        random_credits = 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_credit = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        req_credits = REQ_DEPTH;
        test_words();
        test_lanes();
        test_align();
        test_backpressure();
        test_random();
        check("requester credits at end", 32'(req_credits), 32'(REQ_DEPTH));
        $display("tests run %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
verilog/mem_pkg.sv
verilog/mem_be.sv
verilog/mem.sv
verilog/req_queue.sv
verilog/mem_port.sv
verilog/mem_subsys.sv
test/mem_subsys_checker.sv
test/tb_mem_subsys.sv
